//--- riscv_v_pkg.sv
// ####################################################################
// Shared widths, types and encodings for the vector execution slice
// Integer only, element sizes 8 to 64 bits, register groups of 1 to 4
// ####################################################################
`default_nettype none

package riscv_v_pkg;

    // Scalar and vector data widths
    localparam int RISCV_DATA_WIDTH   = 32;
    localparam int RISCV_V_DATA_WIDTH = 128;
    localparam int RISCV_V_IMM_WIDTH  = 5;
    localparam int BYTE_WIDTH         = 8;

    // Element sizes 8, 16, 32 and 64 bits
    localparam int RISCV_V_NUM_VALID_OSIZES = 4;

    localparam int RISCV_V_NUM_REGS      = 8;
    localparam int RISCV_V_REG_IDX_WIDTH = $clog2(RISCV_V_NUM_REGS);

    // Byte lanes used by the ALU carry chain
    localparam int RISCV_V_NUM_LANES       = RISCV_V_DATA_WIDTH / BYTE_WIDTH;
    localparam int RISCV_V_LANE_IDX_WIDTH  = $clog2(RISCV_V_NUM_LANES);

    typedef logic [RISCV_DATA_WIDTH-1:0]      riscv_data_t;
    typedef logic [RISCV_V_DATA_WIDTH-1:0]    riscv_v_data_t;
    typedef logic [RISCV_V_IMM_WIDTH-1:0]     riscv_v_imm_t;
    // Register index, wraps modulo 8
    typedef logic [RISCV_V_REG_IDX_WIDTH-1:0] vreg_idx_t;
    // 0 is 8, 1 is 16, 2 is 32, 3 is 64 bits
    typedef logic [1:0]                       osize_t;
    typedef logic [1:0]                       beat_t;
    // Group length minus one
    typedef logic [1:0]                       lmul_t;

    // First operand source
    typedef enum logic [1:0] {
        SRC_VEC,
        SRC_SCALAR_INT,
        SRC_SCALAR_IMM,
        SRC_SCALAR_VEC
    } src_sel_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

    // Sequencer states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EXEC,
        ST_DONE
    } seq_state_t;

endpackage : riscv_v_pkg

`default_nettype wire

//--- riscv_v_bypass.sv
// ####################################################################
// Operand bypass, purely combinational
// Scalars are sign-extended and splatted at the element size; srcb
// is never replaced
// ####################################################################
`timescale 1ns/1ps
`default_nettype none

module riscv_v_bypass
    import riscv_v_pkg::*;
(
    input  riscv_data_t   scalar_int,
    input  riscv_v_imm_t  imm,
    input  riscv_v_data_t srca,
    input  riscv_v_data_t srcb,
    input  osize_t        osize,
    input  src_sel_t      src_sel,
    output riscv_v_data_t srca_byp,
    output riscv_v_data_t srcb_byp
);

    riscv_v_data_t sign_ext;
    riscv_v_data_t splat_src;
    riscv_v_data_t splat_by_osize [RISCV_V_NUM_VALID_OSIZES];
    riscv_v_data_t splat;

    // Immediate or scalar integer widened with its own sign bit
    always_comb begin
        if (src_sel == SRC_SCALAR_IMM) begin
            sign_ext = {{(RISCV_V_DATA_WIDTH-RISCV_V_IMM_WIDTH){imm[RISCV_V_IMM_WIDTH-1]}}, imm};
        end else begin
            sign_ext = {{(RISCV_V_DATA_WIDTH-RISCV_DATA_WIDTH){scalar_int[RISCV_DATA_WIDTH-1]}},
                        scalar_int};
        end
    end

    // Element 0 of vs1 is splatted as is
    assign splat_src = (src_sel == SRC_SCALAR_VEC) ? srca : sign_ext;

    // One replicated copy per element size
    for (genvar os = 0; os < RISCV_V_NUM_VALID_OSIZES; os++) begin : g_splat
        localparam int ELEM_WIDTH = (2**os) * BYTE_WIDTH;
        localparam int NUM_ELEMS  = RISCV_V_DATA_WIDTH / ELEM_WIDTH;

        assign splat_by_osize[os] = {NUM_ELEMS{splat_src[ELEM_WIDTH-1:0]}};
    end

    assign splat = splat_by_osize[osize];

    assign srca_byp = (src_sel == SRC_VEC) ? srca : splat;
    assign srcb_byp = srcb;

endmodule : riscv_v_bypass

`default_nettype wire

//--- riscv_v_alu.sv
// ####################################################################
// Element-wise integer ALU computing opb op opa
// Carries never cross an element boundary; SUB gives opb minus opa
// ####################################################################
`timescale 1ns/1ps
`default_nettype none

module riscv_v_alu
    import riscv_v_pkg::*;
(
    input  riscv_v_data_t opa,
    input  riscv_v_data_t opb,
    input  alu_op_t       alu_op,
    input  osize_t        osize,
    output riscv_v_data_t result
);

    logic                              sub_op;
    riscv_v_data_t                     opa_eff;
    riscv_v_data_t                     sum;
    // Low lane-index bits that are zero at an element start
    logic [RISCV_V_LANE_IDX_WIDTH-1:0] lane_mask;

    assign sub_op  = (alu_op == ALU_SUB);
    // Two's complement subtract, the +1 comes in as carry at element start
    assign opa_eff = sub_op ? ~opa : opa;

    assign lane_mask = (RISCV_V_LANE_IDX_WIDTH'(1) << osize) - RISCV_V_LANE_IDX_WIDTH'(1);

    // Byte-lane ripple, carry restarted at each element
    always_comb begin
        logic                carry;
        logic [BYTE_WIDTH:0] lane_sum;

        carry    = 1'b0;
        lane_sum = '0;
        sum      = '0;
        for (int lane = 0; lane < RISCV_V_NUM_LANES; lane++) begin
            if ((RISCV_V_LANE_IDX_WIDTH'(lane) & lane_mask) == '0) begin
                carry = sub_op;
            end
            lane_sum = {1'b0, opb[lane*BYTE_WIDTH +: BYTE_WIDTH]}
                     + {1'b0, opa_eff[lane*BYTE_WIDTH +: BYTE_WIDTH]}
                     + (BYTE_WIDTH+1)'(carry);
            sum[lane*BYTE_WIDTH +: BYTE_WIDTH] = lane_sum[BYTE_WIDTH-1:0];
            carry = lane_sum[BYTE_WIDTH];
        end
    end

    always_comb begin
        case (alu_op)
            ALU_ADD,
            ALU_SUB: result = sum;
            ALU_AND: result = opb & opa;
            ALU_OR:  result = opb | opa;
            ALU_XOR: result = opb ^ opa;
            default: result = '0;
        endcase
    end

    // Opcode must be one of the five defined encodings once driven
    always_comb begin
        a_alu_op_known : assert final ($isunknown(alu_op) ||
                                       alu_op inside {ALU_ADD, ALU_SUB, ALU_AND,
                                                      ALU_OR, ALU_XOR})
            else $error("riscv_v_alu: illegal alu_op %0d", alu_op);
    end

endmodule : riscv_v_alu

`default_nettype wire

//--- riscv_v_regfile.sv
// ####################################################################
// Eight-entry vector register file, cleared at reset
// Operand and destination indices are offset by the beat, modulo 8
// Host load must not coincide with an execution write
// ####################################################################
`timescale 1ns/1ps
`default_nettype none

module riscv_v_regfile
    import riscv_v_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  vreg_idx_t     vs1_idx,
    input  vreg_idx_t     vs2_idx,
    input  vreg_idx_t     vd_idx,
    input  beat_t         beat,
    input  logic          exec_we,
    input  riscv_v_data_t exec_data,
    input  logic          load_en,
    input  vreg_idx_t     load_idx,
    input  riscv_v_data_t load_data,
    input  vreg_idx_t     rd_idx,
    output riscv_v_data_t rda_data,
    output riscv_v_data_t rdb_data,
    output riscv_v_data_t rd_data
);

    riscv_v_data_t regs [RISCV_V_NUM_REGS];
    vreg_idx_t     vs1_eff;
    vreg_idx_t     vs2_eff;
    vreg_idx_t     vd_eff;

    // Group member for this beat, wrapping past register 7
    assign vs1_eff = vs1_idx + vreg_idx_t'(beat);
    assign vs2_eff = vs2_idx + vreg_idx_t'(beat);
    assign vd_eff  = vd_idx + vreg_idx_t'(beat);

    assign rda_data = regs[vs1_eff];
    assign rdb_data = regs[vs2_eff];
    assign rd_data  = regs[rd_idx];

    // Single write port, execution takes priority
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < RISCV_V_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (exec_we) begin
            regs[vd_eff] <= exec_data;
        end else if (load_en) begin
            regs[load_idx] <= load_data;
        end
    end

    // Host loads only while no operation is in flight
    a_no_load_during_exec : assert property (
        @(posedge clk) disable iff (!rst_n) !(exec_we && load_en)
    ) else $error("riscv_v_regfile: host load during execution write");

endmodule : riscv_v_regfile

`default_nettype wire

//--- riscv_v_beat_counter.sv
// ####################################################################
// Beat counter for one register group, 0 up to lmul
// Holds at lmul until the next start
// ####################################################################
`timescale 1ns/1ps
`default_nettype none

module riscv_v_beat_counter
    import riscv_v_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start,
    input  logic  advance,
    input  lmul_t lmul,
    output beat_t beat,
    output logic  last_beat
);

    assign last_beat = (beat == beat_t'(lmul));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat <= '0;
        end else if (start) begin
            beat <= '0;
        end else if (advance && !last_beat) begin
            beat <= beat + beat_t'(1);
        end
    end

    // Beat stays inside the group while stepping
    a_beat_in_group : assert property (
        @(posedge clk) disable iff (!rst_n)
        advance |=> (beat <= beat_t'($past(lmul)))
    ) else $error("riscv_v_beat_counter: beat advanced past lmul");

endmodule : riscv_v_beat_counter

`default_nettype wire

//--- riscv_v_seq_fsm.sv
// ####################################################################
// Four-phase req/ack sequencer, one writeback beat per cycle
// Request fields must stay stable from req rise until ack rises
// ####################################################################
`timescale 1ns/1ps
`default_nettype none

module riscv_v_seq_fsm
    import riscv_v_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic req,
    input  logic last_beat,
    output logic ack,
    output logic start,
    output logic advance,
    output logic exec_we
);

    seq_state_t state;
    seq_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (req) begin
                    state_next = ST_EXEC;
                end
            end
            // Leave after the write of the final beat
            ST_EXEC: begin
                if (last_beat) begin
                    state_next = ST_DONE;
                end
            end
            ST_DONE: begin
                if (!req) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    assign start   = (state == ST_IDLE) && req;
    assign exec_we = (state == ST_EXEC);
    assign advance = (state == ST_EXEC);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            ack   <= 1'b0;
        end else begin
            state <= state_next;
            // Registered so ack rises with the last write
            ack   <= (state_next == ST_DONE);
        end
    end

    a_done_has_ack : assert property (
        @(posedge clk) disable iff (!rst_n) !ack |-> (state != ST_DONE)
    ) else $error("riscv_v_seq_fsm: ST_DONE without ack");

    // A write always precedes ack and never overlaps it
    a_write_before_ack : assert property (
        @(posedge clk) disable iff (!rst_n) $rose(ack) |-> $past(exec_we) && !exec_we
    ) else $error("riscv_v_seq_fsm: ack rose without a final write");

endmodule : riscv_v_seq_fsm

`default_nettype wire

//--- riscv_v_exec_unit.sv
// ####################################################################
// Vector integer execution slice top level
// Host load and read ports stand in for vector load/store; loads only
// while idle. No masking, tail policy or exceptions
// ####################################################################
`timescale 1ns/1ps
`default_nettype none

module riscv_v_exec_unit
    import riscv_v_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          req,
    input  src_sel_t      src_sel,
    input  alu_op_t       alu_op,
    input  osize_t        osize,
    input  lmul_t         lmul,
    input  vreg_idx_t     vs1_idx,
    input  vreg_idx_t     vs2_idx,
    input  vreg_idx_t     vd_idx,
    input  riscv_data_t   scalar_int,
    input  riscv_v_imm_t  imm,
    input  logic          load_en,
    input  vreg_idx_t     load_idx,
    input  riscv_v_data_t load_data,
    input  vreg_idx_t     rd_idx,
    output logic          ack,
    output riscv_v_data_t rd_data
);

    logic          start;
    logic          advance;
    logic          exec_we;
    logic          last_beat;
    beat_t         beat;
    riscv_v_data_t rda_data;
    riscv_v_data_t rdb_data;
    riscv_v_data_t srca_byp;
    riscv_v_data_t srcb_byp;
    riscv_v_data_t alu_result;

    riscv_v_seq_fsm i_seq_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .last_beat (last_beat),
        .ack       (ack),
        .start     (start),
        .advance   (advance),
        .exec_we   (exec_we)
    );

    riscv_v_beat_counter i_beat_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .advance   (advance),
        .lmul      (lmul),
        .beat      (beat),
        .last_beat (last_beat)
    );

    riscv_v_regfile i_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .vs1_idx   (vs1_idx),
        .vs2_idx   (vs2_idx),
        .vd_idx    (vd_idx),
        .beat      (beat),
        .exec_we   (exec_we),
        .exec_data (alu_result),
        .load_en   (load_en),
        .load_idx  (load_idx),
        .load_data (load_data),
        .rd_idx    (rd_idx),
        .rda_data  (rda_data),
        .rdb_data  (rdb_data),
        .rd_data   (rd_data)
    );

    riscv_v_bypass i_bypass (
        .scalar_int (scalar_int),
        .imm        (imm),
        .srca       (rda_data),
        .srcb       (rdb_data),
        .osize      (osize),
        .src_sel    (src_sel),
        .srca_byp   (srca_byp),
        .srcb_byp   (srcb_byp)
    );

    riscv_v_alu i_alu (
        .opa    (srca_byp),
        .opb    (srcb_byp),
        .alu_op (alu_op),
        .osize  (osize),
        .result (alu_result)
    );

endmodule : riscv_v_exec_unit

`default_nettype wire

//--- tb_riscv_v_exec_unit.sv
// ####################################################################
// Directed testbench for the vector execution slice
// Expected values come from a behavioral model of operand splat and
// element arithmetic; outputs are sampled on the falling clock edge
// ####################################################################
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_v_exec_unit
    import riscv_v_pkg::*;
;

    localparam int TIMEOUT_CYCLES = 50;

    logic          clk;
    logic          rst_n;
    logic          req;
    src_sel_t      src_sel;
    alu_op_t       alu_op;
    osize_t        osize;
    lmul_t         lmul;
    vreg_idx_t     vs1_idx;
    vreg_idx_t     vs2_idx;
    vreg_idx_t     vd_idx;
    riscv_data_t   scalar_int;
    riscv_v_imm_t  imm;
    logic          load_en;
    vreg_idx_t     load_idx;
    riscv_v_data_t load_data;
    vreg_idx_t     rd_idx;
    logic          ack;
    riscv_v_data_t rd_data;

    riscv_v_data_t model_regs [RISCV_V_NUM_REGS];
    int            errors;
    integer        seed;

    riscv_v_exec_unit i_riscv_v_exec_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .src_sel    (src_sel),
        .alu_op     (alu_op),
        .osize      (osize),
        .lmul       (lmul),
        .vs1_idx    (vs1_idx),
        .vs2_idx    (vs2_idx),
        .vd_idx     (vd_idx),
        .scalar_int (scalar_int),
        .imm        (imm),
        .load_en    (load_en),
        .load_idx   (load_idx),
        .load_data  (load_data),
        .rd_idx     (rd_idx),
        .ack        (ack),
        .rd_data    (rd_data)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic riscv_v_data_t rand_vec();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    function automatic logic [63:0] elem_mask(int width);
        return (width == 64) ? 64'hffff_ffff_ffff_ffff : ((64'd1 << width) - 64'd1);
    endfunction

    // First operand as the requester sees it: vector or splatted scalar
    function automatic riscv_v_data_t model_operand(src_sel_t src, riscv_v_data_t a,
                                                    riscv_data_t sint, riscv_v_imm_t im,
                                                    osize_t os);
        riscv_v_data_t full;
        riscv_v_data_t res;
        int            width;
        width = 8 << os;
        res   = '0;
        case (src)
            SRC_SCALAR_INT: full = {{96{sint[31]}}, sint};
            SRC_SCALAR_IMM: full = {{123{im[4]}}, im};
            default:        full = a;
        endcase
        for (int e = 0; e < 128 / width; e++) begin
            res |= riscv_v_data_t'(full[63:0] & elem_mask(width)) << (e * width);
        end
        return (src == SRC_VEC) ? a : res;
    endfunction

    // vs2 op operand, each element wraps on its own
    function automatic riscv_v_data_t model_elems(riscv_v_data_t a, riscv_v_data_t b,
                                                  alu_op_t op, osize_t os);
        riscv_v_data_t res;
        logic [63:0]   ea;
        logic [63:0]   eb;
        logic [63:0]   er;
        int            width;
        width = 8 << os;
        res   = '0;
        for (int e = 0; e < 128 / width; e++) begin
            ea = 64'(a >> (e * width)) & elem_mask(width);
            eb = 64'(b >> (e * width)) & elem_mask(width);
            case (op)
                ALU_ADD: er = eb + ea;
                ALU_SUB: er = eb - ea;
                ALU_AND: er = eb & ea;
                ALU_OR:  er = eb | ea;
                default: er = eb ^ ea;
            endcase
            res |= riscv_v_data_t'(er & elem_mask(width)) << (e * width);
        end
        return res;
    endfunction

    // One beat at a time so overlapping groups see earlier writes
    task automatic model_op(src_sel_t src, alu_op_t op, osize_t os, lmul_t lm,
                            vreg_idx_t v1, vreg_idx_t v2, vreg_idx_t vd,
                            riscv_data_t sint, riscv_v_imm_t im);
        riscv_v_data_t opa;
        for (int b = 0; b <= lm; b++) begin
            opa = model_operand(src, model_regs[vreg_idx_t'(v1 + b)], sint, im, os);
            model_regs[vreg_idx_t'(vd + b)] =
                model_elems(opa, model_regs[vreg_idx_t'(v2 + b)], op, os);
        end
    endtask

    task automatic check_vec(string name, riscv_v_data_t exp, riscv_v_data_t act);
        assert (act === exp) else begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_int(string name, int exp, int act);
        assert (act == exp) else begin
            errors++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic load_reg(vreg_idx_t idx, riscv_v_data_t data);
        @(posedge clk);
        load_en   <= 1'b1;
        load_idx  <= idx;
        load_data <= data;
        @(posedge clk);
        load_en   <= 1'b0;
        model_regs[idx] = data;
    endtask

    task automatic read_check(string name, vreg_idx_t idx);
        @(posedge clk);
        rd_idx <= idx;
        @(negedge clk);
        check_vec($sformatf("%s v%0d", name, idx), model_regs[idx], rd_data);
    endtask

    task automatic check_all_regs(string name);
        for (int i = 0; i < RISCV_V_NUM_REGS; i++) begin
            read_check(name, vreg_idx_t'(i));
        end
    endtask

    // Full four-phase handshake, ack held for hold extra cycles
    task automatic run_op(string name, src_sel_t src, alu_op_t op, osize_t os, lmul_t lm,
                          vreg_idx_t v1, vreg_idx_t v2, vreg_idx_t vd,
                          riscv_data_t sint, riscv_v_imm_t im, int hold);
        int cycles;
        @(posedge clk);
        src_sel    <= src;
        alu_op     <= op;
        osize      <= os;
        lmul       <= lm;
        vs1_idx    <= v1;
        vs2_idx    <= v2;
        vd_idx     <= vd;
        scalar_int <= sint;
        imm        <= im;
        req        <= 1'b1;
        // Cycles counted from the edge that drives req
        cycles = 0;
        @(negedge clk);
        while (!ack && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!ack) begin
            errors++;
            $display("%s: timed out waiting for ack to rise", name);
        end else begin
            check_int({name, " ack latency"}, lm + 2, cycles);
        end
        repeat (hold) begin
            @(negedge clk);
            check_int({name, " ack held"}, 1, ack);
        end
        @(posedge clk);
        req <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (ack && cycles < TIMEOUT_CYCLES);
        if (ack) begin
            errors++;
            $display("%s: timed out waiting for ack to fall", name);
        end else begin
            check_int({name, " ack release"}, 2, cycles);
        end
        model_op(src, op, os, lm, v1, v2, vd, sint, im);
        check_all_regs(name);
    endtask

    initial begin
        alu_op_t op;
        seed = 32'hf9fe;
        errors = 0;
        for (int i = 0; i < RISCV_V_NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        rst_n      <= 1'b0;
        req        <= 1'b0;
        src_sel    <= SRC_VEC;
        alu_op     <= ALU_ADD;
        osize      <= '0;
        lmul       <= '0;
        vs1_idx    <= '0;
        vs2_idx    <= '0;
        vd_idx     <= '0;
        scalar_int <= '0;
        imm        <= '0;
        load_en    <= 1'b0;
        load_idx   <= '0;
        load_data  <= '0;
        rd_idx     <= '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_int("reset ack", 0, ack);

        // Registers clear at reset, then load and read back
        check_all_regs("reset");
        for (int i = 0; i < RISCV_V_NUM_REGS; i++) begin
            load_reg(vreg_idx_t'(i), rand_vec());
        end
        check_all_regs("load");

        // Vector-vector, LMUL 1, every op at every size
        for (int os = 0; os < RISCV_V_NUM_VALID_OSIZES; os++) begin
            for (int o = 0; o < 5; o++) begin
                op = alu_op_t'(o);
                load_reg(1, rand_vec());
                load_reg(2, rand_vec());
                run_op($sformatf("vv %s os%0d", op.name(), os), SRC_VEC, op,
                       osize_t'(os), 0, 1, 2, 3, '0, '0, 0);
            end
            // All-ones plus one must not carry out of any element
            load_reg(1, {16{8'h01}});
            load_reg(2, {16{8'hff}});
            run_op($sformatf("carry os%0d", os), SRC_VEC, ALU_ADD, osize_t'(os), 0,
                   1, 2, 4, '0, '0, 0);
        end

        // Scalar and immediate broadcast with sign extension
        for (int os = 0; os < RISCV_V_NUM_VALID_OSIZES; os++) begin
            run_op($sformatf("sint neg os%0d", os), SRC_SCALAR_INT, ALU_ADD, osize_t'(os),
                   0, 0, 5, 6, 32'h8000_12fb, '0, 0);
            run_op($sformatf("sint pos os%0d", os), SRC_SCALAR_INT, ALU_SUB, osize_t'(os),
                   0, 0, 5, 7, 32'h1234_5678, '0, 0);
            run_op($sformatf("imm -16 os%0d", os), SRC_SCALAR_IMM, ALU_ADD, osize_t'(os),
                   0, 0, 2, 6, '0, 5'h10, 0);
            run_op($sformatf("imm 15 os%0d", os), SRC_SCALAR_IMM, ALU_XOR, osize_t'(os),
                   0, 0, 2, 7, '0, 5'h0f, 0);
            run_op($sformatf("splat os%0d", os), SRC_SCALAR_VEC, ALU_ADD, osize_t'(os),
                   0, 3, 4, 5, '0, '0, 0);
        end

        // Register groups wrapping past v7, last one reads its own writes
        for (int lm = 1; lm < 4; lm++) begin
            for (int i = 0; i < RISCV_V_NUM_REGS; i++) begin
                load_reg(vreg_idx_t'(i), rand_vec());
            end
            run_op($sformatf("group lmul%0d", lm + 1), SRC_VEC, ALU_SUB, osize_t'(lm),
                   lmul_t'(lm), 6, 7, 3, '0, '0, 0);
        end
        run_op("group overlap", SRC_VEC, ALU_ADD, 1, 2, 4, 7, 0, '0, '0, 0);

        // Back-pressure on ack, then a second operation
        run_op("hold ack", SRC_SCALAR_INT, ALU_OR, 2, 1, 2, 3, 4, 32'hdead_beef, '0, 5);
        run_op("after hold", SRC_VEC, ALU_AND, 0, 0, 4, 5, 1, '0, '0, 0);

        $display("Closing: %0d error(s) counted", errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule : tb_riscv_v_exec_unit

`default_nettype wire

//--- files.f
riscv_v_pkg.sv
riscv_v_bypass.sv
riscv_v_alu.sv
riscv_v_regfile.sv
riscv_v_beat_counter.sv
riscv_v_seq_fsm.sv
riscv_v_exec_unit.sv
tb_riscv_v_exec_unit.sv
